// File: include/cpu_config.svh
/*
  Bus widths, vectors, opcodes and internal encodings for the 6502 subset core.
  Opcode values follow the NMOS 6502 encoding. Only the opcodes listed here
  are executed; any other byte sends the core into its error state.
*/
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

`define ADDR_W 16
`define DATA_W 8

// Reset vector, low byte first
`define RESET_VEC_LO 16'hFFFC
`define RESET_VEC_HI 16'hFFFD

// ----------------------------------------------------------------------
// Opcodes of the kept instruction set
// ----------------------------------------------------------------------
`define OP_CLC     8'h18
`define OP_SEC     8'h38
`define OP_CLV     8'hB8
`define OP_NOP     8'hEA
`define OP_LDA_IMM 8'hA9
`define OP_LDX_IMM 8'hA2
`define OP_LDY_IMM 8'hA0
`define OP_ASL_ACC 8'h0A
`define OP_LSR_ACC 8'h4A
`define OP_ROL_ACC 8'h2A
`define OP_ROR_ACC 8'h6A
`define OP_LDA_ABS 8'hAD
`define OP_LDX_ABS 8'hAE
`define OP_LDY_ABS 8'hAC
`define OP_STA_ABS 8'h8D
`define OP_STX_ABS 8'h8E
`define OP_STY_ABS 8'h8C
`define OP_JMP_ABS 8'h4C
`define OP_ADC_ABS 8'h6D
`define OP_SBC_ABS 8'hED
`define OP_AND_ABS 8'h2D
`define OP_ORA_ABS 8'h0D
`define OP_EOR_ABS 8'h4D
`define OP_CMP_ABS 8'hCD

// ALU operations
`define ALU_OP_W 3
`define ALU_ADD  3'd0
`define ALU_SUB  3'd1
`define ALU_AND  3'd2
`define ALU_OR   3'd3
`define ALU_XOR  3'd4
`define ALU_SHL  3'd5
`define ALU_SHR  3'd6

// One-hot state bit indices
`define ST_RESET  0
`define ST_VEC1   1
`define ST_VEC2   2
`define ST_FETCH  3
`define ST_DECODE 4
`define ST_ABS1   5
`define ST_ABS2   6
`define ST_ERROR  7
`define ST_N      8

// Status register bits
`define FLAG_C 0
`define FLAG_Z 1
`define FLAG_U 5
`define FLAG_V 6
`define FLAG_N 7

// Flag update masks
`define MASK_C    (8'h01 << `FLAG_C)
`define MASK_V    (8'h01 << `FLAG_V)
`define MASK_NZ   ((8'h01 << `FLAG_N) | (8'h01 << `FLAG_Z))
`define MASK_NZC  (`MASK_NZ | `MASK_C)
`define MASK_NZCV (`MASK_NZC | `MASK_V)

// Addressing class
`define MODE_W      2
`define MODE_SINGLE 2'd0
`define MODE_IMM    2'd1
`define MODE_ABS    2'd2
`define MODE_ILL    2'd3

// Register select, shared by ALU source and store source
`define SEL_W 2
`define SRC_A 2'd0
`define SRC_X 2'd1
`define SRC_Y 2'd2

// Carry-in select
`define CSEL_ZERO 2'd0
`define CSEL_ONE  2'd1
`define CSEL_PC   2'd2

`endif

// File: src/cpu_pkg.sv
/*
  Shared types of the 6502 subset core.
  The opcode byte is read either whole or as the aaa/bbb/cc fields.
*/
`include "cpu_config.svh"

package cpu_pkg;

  // Opcode byte with its 6502 field layout
  typedef struct packed {
    logic [2:0] aaa;
    logic [2:0] bbb;
    logic [1:0] cc;
  } opcode_fields_t;

  typedef union packed {
    logic [`DATA_W-1:0] raw;
    opcode_fields_t     f;
  } opcode_t;

endpackage

// File: src/alu_if.sv
/*
  ALU request/result bundle and the decoded control bundle.
  Both are plain combinational levels with no handshake.
*/
`timescale 1ns/1ps
`include "cpu_config.svh"

interface alu_if;
  logic [`ALU_OP_W-1:0] op;
  logic [`DATA_W-1:0]   a;
  logic [`DATA_W-1:0]   b;
  logic                 carry_in;
  logic [`DATA_W-1:0]   result;
  logic                 carry_out;
  logic                 overflow;

  modport requester (output op, a, b, carry_in, input result, carry_out, overflow);
  modport alu (input op, a, b, carry_in, output result, carry_out, overflow);
endinterface

interface ctrl_if;
  logic [`MODE_W-1:0]   mode;
  logic [`ALU_OP_W-1:0] alu_op;
  logic [`SEL_W-1:0]    alu_src;
  logic [1:0]           carry_sel;
  logic                 wb_a;
  logic                 wb_x;
  logic                 wb_y;
  logic [7:0]           flag_mask;
  logic [`SEL_W-1:0]    store_src;
  logic                 is_store;
  logic                 is_jmp;
  logic                 is_alu;

  modport decoder (
    output mode, alu_op, alu_src, carry_sel, wb_a, wb_x, wb_y,
           flag_mask, store_src, is_store, is_jmp, is_alu
  );
  modport datapath (
    input mode, alu_op, alu_src, carry_sel, wb_a, wb_x, wb_y,
          flag_mask, store_src, is_store, is_jmp, is_alu
  );
  modport sequencer (input mode, is_jmp);
endinterface

// File: src/cpu_alu.sv
/*
  8-bit combinational ALU.
  Subtract is a + ~b + carry_in, so carry set means no borrow.
  Overflow is only meaningful for add and subtract.
*/
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_alu (
  alu_if.alu bus
);

  logic [`DATA_W-1:0] b_eff;
  logic [`DATA_W:0]   sum;

  always_comb begin
    // Subtract reuses the adder with b inverted
    b_eff = (bus.op == `ALU_SUB) ? ~bus.b : bus.b;
    sum   = {1'b0, bus.a} + {1'b0, b_eff} + {{`DATA_W{1'b0}}, bus.carry_in};

    bus.result    = '0;
    bus.carry_out = 1'b0;
    bus.overflow  = 1'b0;

    case (bus.op)
      `ALU_ADD, `ALU_SUB: begin
        bus.result    = sum[`DATA_W-1:0];
        bus.carry_out = sum[`DATA_W];
        // Signed overflow when both inputs agree in sign and the sum does not
        bus.overflow  = (bus.a[`DATA_W-1] == b_eff[`DATA_W-1]) &&
                        (sum[`DATA_W-1] != bus.a[`DATA_W-1]);
      end
      `ALU_AND: begin
        bus.result = bus.a & bus.b;
      end
      `ALU_OR: begin
        bus.result = bus.a | bus.b;
      end
      `ALU_XOR: begin
        bus.result = bus.a ^ bus.b;
      end
      `ALU_SHL: begin
        bus.result    = {bus.a[`DATA_W-2:0], bus.carry_in};
        bus.carry_out = bus.a[`DATA_W-1];
      end
      `ALU_SHR: begin
        bus.result    = {bus.carry_in, bus.a[`DATA_W-1:1]};
        bus.carry_out = bus.a[0];
      end
      default: begin
        bus.result = '0;
      end
    endcase
  end

endmodule

// File: src/cpu_decoder.sv
/*
  Instruction decoder, purely combinational.
  Addressing class comes from the bbb/cc fields; the operation and the
  legality check come from the whole byte. Unknown bytes report illegal.
*/
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_decoder (
  input cpu_pkg::opcode_t opcode,
  ctrl_if.decoder         ctrl
);

  logic [`MODE_W-1:0] field_mode;

  // ----------------------------------------------------------------------
  // Addressing class from the field layout
  // ----------------------------------------------------------------------
  always_comb begin
    field_mode = `MODE_ILL;
    case (opcode.f.bbb)
      3'b011:  field_mode = `MODE_ABS;
      // #imm in group 01, accumulator in group 10
      3'b010:  field_mode = (opcode.f.cc == 2'b01) ? `MODE_IMM : `MODE_SINGLE;
      3'b000:  field_mode = (opcode.f.cc != 2'b01) ? `MODE_IMM : `MODE_ILL;
      default: field_mode = `MODE_ILL;
    endcase
  end

  // ----------------------------------------------------------------------
  // Operation fields from the whole byte
  // ----------------------------------------------------------------------
  always_comb begin
    ctrl.mode      = `MODE_ILL;
    ctrl.alu_op    = `ALU_ADD;
    ctrl.alu_src   = `SRC_A;
    ctrl.carry_sel = `CSEL_ZERO;
    ctrl.wb_a      = 1'b0;
    ctrl.wb_x      = 1'b0;
    ctrl.wb_y      = 1'b0;
    ctrl.flag_mask = '0;
    ctrl.store_src = `SRC_A;
    ctrl.is_store  = 1'b0;
    ctrl.is_jmp    = 1'b0;
    ctrl.is_alu    = 1'b0;

    case (opcode.raw)
      // Implied and JMP matched on the whole byte
      `OP_CLC: begin
        ctrl.mode      = `MODE_SINGLE;
        ctrl.flag_mask = `MASK_C;
      end
      `OP_SEC: begin
        ctrl.mode      = `MODE_SINGLE;
        ctrl.flag_mask = `MASK_C;
        ctrl.carry_sel = `CSEL_ONE;
      end
      `OP_CLV: begin
        ctrl.mode      = `MODE_SINGLE;
        ctrl.flag_mask = `MASK_V;
      end
      `OP_NOP: ctrl.mode = `MODE_SINGLE;
      `OP_JMP_ABS: begin
        ctrl.mode   = `MODE_ABS;
        ctrl.is_jmp = 1'b1;
      end

      // Loads
      `OP_LDA_IMM, `OP_LDA_ABS: begin
        ctrl.mode      = field_mode;
        ctrl.wb_a      = 1'b1;
        ctrl.flag_mask = `MASK_NZ;
      end
      `OP_LDX_IMM, `OP_LDX_ABS: begin
        ctrl.mode      = field_mode;
        ctrl.wb_x      = 1'b1;
        ctrl.flag_mask = `MASK_NZ;
      end
      `OP_LDY_IMM, `OP_LDY_ABS: begin
        ctrl.mode      = field_mode;
        ctrl.wb_y      = 1'b1;
        ctrl.flag_mask = `MASK_NZ;
      end

      // Stores
      `OP_STA_ABS, `OP_STX_ABS, `OP_STY_ABS: begin
        ctrl.mode      = field_mode;
        ctrl.is_store  = 1'b1;
        ctrl.store_src = (opcode.raw == `OP_STX_ABS) ? `SRC_X :
                         (opcode.raw == `OP_STY_ABS) ? `SRC_Y : `SRC_A;
      end

      // Accumulator shifts, rotates pull in P.C
      `OP_ASL_ACC, `OP_ROL_ACC, `OP_LSR_ACC, `OP_ROR_ACC: begin
        ctrl.mode      = field_mode;
        ctrl.is_alu    = 1'b1;
        ctrl.wb_a      = 1'b1;
        ctrl.flag_mask = `MASK_NZC;
        ctrl.alu_op    = (opcode.raw == `OP_ASL_ACC || opcode.raw == `OP_ROL_ACC) ?
                         `ALU_SHL : `ALU_SHR;
        ctrl.carry_sel = (opcode.raw == `OP_ROL_ACC || opcode.raw == `OP_ROR_ACC) ?
                         `CSEL_PC : `CSEL_ZERO;
      end

      // Absolute ALU group
      `OP_ADC_ABS, `OP_SBC_ABS: begin
        ctrl.mode      = field_mode;
        ctrl.is_alu    = 1'b1;
        ctrl.wb_a      = 1'b1;
        ctrl.flag_mask = `MASK_NZCV;
        ctrl.carry_sel = `CSEL_PC;
        ctrl.alu_op    = (opcode.raw == `OP_SBC_ABS) ? `ALU_SUB : `ALU_ADD;
      end
      `OP_AND_ABS, `OP_ORA_ABS, `OP_EOR_ABS: begin
        ctrl.mode      = field_mode;
        ctrl.is_alu    = 1'b1;
        ctrl.wb_a      = 1'b1;
        ctrl.flag_mask = `MASK_NZ;
        ctrl.alu_op    = (opcode.raw == `OP_AND_ABS) ? `ALU_AND :
                         (opcode.raw == `OP_ORA_ABS) ? `ALU_OR : `ALU_XOR;
      end
      `OP_CMP_ABS: begin
        // Flags only, A is left alone
        ctrl.mode      = field_mode;
        ctrl.is_alu    = 1'b1;
        ctrl.alu_op    = `ALU_SUB;
        ctrl.carry_sel = `CSEL_ONE;
        ctrl.flag_mask = `MASK_NZC;
      end

      default: ctrl.mode = `MODE_ILL;
    endcase
  end

endmodule

// File: src/cpu_sequencer.sv
/*
  One-hot instruction sequencer.
  ERROR is only left through reset; a corrupt state vector also lands there.
*/
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_sequencer (
  input  logic              clk,
  input  logic              resetn,
  ctrl_if.sequencer         ctrl,
  output logic [`ST_N-1:0]  state
);

  logic [`ST_N-1:0] next;

  always_comb begin
    next = '0;
    case (1'b1)
      state[`ST_RESET]: next[`ST_VEC1]  = 1'b1;
      state[`ST_VEC1]:  next[`ST_VEC2]  = 1'b1;
      state[`ST_VEC2]:  next[`ST_FETCH] = 1'b1;
      state[`ST_FETCH]: next[`ST_DECODE] = 1'b1;

      state[`ST_DECODE]: begin
        case (ctrl.mode)
          `MODE_SINGLE, `MODE_IMM: next[`ST_FETCH] = 1'b1;
          `MODE_ABS:               next[`ST_ABS1]  = 1'b1;
          default:                 next[`ST_ERROR] = 1'b1;
        endcase
      end

      // JMP is done once the target high byte is in
      state[`ST_ABS1]: begin
        if (ctrl.is_jmp) begin
          next[`ST_FETCH] = 1'b1;
        end else begin
          next[`ST_ABS2] = 1'b1;
        end
      end

      state[`ST_ABS2]:  next[`ST_FETCH] = 1'b1;
      state[`ST_ERROR]: next[`ST_ERROR] = 1'b1;
      default:          next[`ST_ERROR] = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= '0;
      state[`ST_RESET] <= 1'b1;
    end else begin
      state <= next;
    end
  end

endmodule

// File: src/cpu_datapath.sv
/*
  Registers, PC arithmetic and bus drivers of the 6502 subset core.
  Memory reads are assumed combinational on the registered address.
  ALU and shift results reach A and P at the following FETCH.
*/
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_datapath (
  input  logic                 clk,
  input  logic                 resetn,
  input  logic [`DATA_W-1:0]   rd_data,
  input  logic [`ST_N-1:0]     state,
  ctrl_if.datapath             ctrl,
  alu_if.requester             alu,
  output cpu_pkg::opcode_t     opcode,
  output logic [`ADDR_W-1:0]   address,
  output logic [`DATA_W-1:0]   wr_data,
  output logic                 wr_enable
);

  import cpu_pkg::*;

  // Architectural registers
  logic [`DATA_W-1:0] acc;
  logic [`DATA_W-1:0] x_reg;
  logic [`DATA_W-1:0] y_reg;
  logic [7:0]         status;
  logic [`ADDR_W-1:0] pc;
  opcode_t            ir;

  // Low operand byte, held until the high byte arrives
  logic [`DATA_W-1:0] oper_lo;
  logic               pending;

  logic [`DATA_W-1:0] src_val;
  logic [`DATA_W-1:0] store_val;
  logic               carry_val;
  logic               alu_now;
  logic               load_now;

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  function automatic logic [`DATA_W-1:0] pick_reg(
    input logic [`SEL_W-1:0]  sel,
    input logic [`DATA_W-1:0] a,
    input logic [`DATA_W-1:0] x,
    input logic [`DATA_W-1:0] y
  );
    case (sel)
      `SRC_X:  return x;
      `SRC_Y:  return y;
      default: return a;
    endcase
  endfunction

  // Replace the masked bits of P, N and Z always come from res
  function automatic logic [7:0] upd_flags(
    input logic [7:0]         p,
    input logic [7:0]         mask,
    input logic [`DATA_W-1:0] res,
    input logic               c,
    input logic               v
  );
    logic [7:0] f;
    f = p;
    f[`FLAG_N] = res[`DATA_W-1];
    f[`FLAG_Z] = ~|res;
    f[`FLAG_C] = c;
    f[`FLAG_V] = v;
    return (p & ~mask) | (f & mask);
  endfunction

  assign src_val   = pick_reg(ctrl.alu_src, acc, x_reg, y_reg);
  assign store_val = pick_reg(ctrl.store_src, acc, x_reg, y_reg);
  assign carry_val = (ctrl.carry_sel == `CSEL_PC) ? status[`FLAG_C] :
                     (ctrl.carry_sel == `CSEL_ONE);

  // Shifts grab A in DECODE, absolute ALU ops grab memory in ABS2
  assign alu_now  = ctrl.is_alu &&
                    ((state[`ST_DECODE] && ctrl.mode == `MODE_SINGLE) || state[`ST_ABS2]);
  assign load_now = !ctrl.is_alu &&
                    ((state[`ST_DECODE] && ctrl.mode == `MODE_IMM) || state[`ST_ABS2]);

  assign opcode = ir;

  // ----------------------------------------------------------------------
  // Instruction cycle
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      address   <= `RESET_VEC_LO;
      wr_enable <= 1'b0;
      status    <= '0;
      status[`FLAG_U] <= 1'b1;
      x_reg     <= '0;
      y_reg     <= '0;
      pending   <= 1'b0;
    end else begin
      case (1'b1)
        state[`ST_VEC1]: begin
          pc[`DATA_W-1:0] <= rd_data;
          address <= `RESET_VEC_HI;
        end

        state[`ST_VEC2]: begin
          pc[`ADDR_W-1:`DATA_W] <= rd_data;
          address <= {rd_data, pc[`DATA_W-1:0]};
        end

        state[`ST_FETCH]: begin
          ir      <= rd_data;
          address <= pc + `ADDR_W'(1);
          // ctrl still decodes the previous instruction here
          if (pending) begin
            pending <= 1'b0;
            if (ctrl.wb_a) begin
              acc <= alu.result;
            end
            status <= upd_flags(status, ctrl.flag_mask, alu.result,
                                alu.carry_out, alu.overflow);
          end
        end

        state[`ST_DECODE]: begin
          oper_lo <= rd_data;
          case (ctrl.mode)
            `MODE_SINGLE: begin
              pc      <= pc + `ADDR_W'(1);
              address <= pc + `ADDR_W'(1);
              // CLC, SEC and CLV act right away
              if (!ctrl.is_alu) begin
                status <= upd_flags(status, ctrl.flag_mask, '0, carry_val, 1'b0);
              end
            end
            `MODE_IMM: begin
              pc      <= pc + `ADDR_W'(2);
              address <= pc + `ADDR_W'(2);
            end
            `MODE_ABS: address <= pc + `ADDR_W'(2);
            default: ;  // illegal, bus frozen
          endcase
        end

        state[`ST_ABS1]: begin
          address <= {rd_data, oper_lo};
          if (ctrl.is_jmp) begin
            pc <= {rd_data, oper_lo};
          end
          if (ctrl.is_store) begin
            wr_data   <= store_val;
            wr_enable <= 1'b1;
          end
        end

        state[`ST_ABS2]: begin
          wr_enable <= 1'b0;
          pc        <= pc + `ADDR_W'(3);
          address   <= pc + `ADDR_W'(3);
        end

        default: ;
      endcase

      // Operand capture for the deferred commit
      if (alu_now) begin
        alu.op       <= ctrl.alu_op;
        alu.a        <= src_val;
        alu.b        <= rd_data;
        alu.carry_in <= carry_val;
        pending      <= 1'b1;
      end

      // Loads write straight into the register; stores carry an empty mask
      if (load_now) begin
        if (ctrl.wb_a) begin
          acc <= rd_data;
        end
        if (ctrl.wb_x) begin
          x_reg <= rd_data;
        end
        if (ctrl.wb_y) begin
          y_reg <= rd_data;
        end
        status <= upd_flags(status, ctrl.flag_mask, rd_data,
                            status[`FLAG_C], status[`FLAG_V]);
      end
    end
  end

endmodule

// File: src/cpu_top.sv
/*
  Top level of the 6502 subset core.
  rd_data must reflect mem[address] in the same cycle; writes land on the
  rising edge where wr_enable is high.
*/
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_top (
  input  logic               clk,
  input  logic               resetn,
  input  logic [`DATA_W-1:0] rd_data,
  output logic [`ADDR_W-1:0] address,
  output logic [`DATA_W-1:0] wr_data,
  output logic               wr_enable
);

  import cpu_pkg::*;

  opcode_t          opcode;
  logic [`ST_N-1:0] state;

  alu_if  alu_bus ();
  ctrl_if ctrl_bus ();

  cpu_sequencer i_sequencer (
    .clk    (clk),
    .resetn (resetn),
    .ctrl   (ctrl_bus.sequencer),
    .state  (state)
  );

  cpu_decoder i_decoder (
    .opcode (opcode),
    .ctrl   (ctrl_bus.decoder)
  );

  cpu_datapath i_datapath (
    .clk       (clk),
    .resetn    (resetn),
    .rd_data   (rd_data),
    .state     (state),
    .ctrl      (ctrl_bus.datapath),
    .alu       (alu_bus.requester),
    .opcode    (opcode),
    .address   (address),
    .wr_data   (wr_data),
    .wr_enable (wr_enable)
  );

  cpu_alu i_alu (
    .bus (alu_bus.alu)
  );

endmodule

// File: bench/tb_cpu_top.sv
/*
  Testbench for the 6502 subset core. A random program is built in a memory
  image and a reference model predicts every bus cycle, which is compared at
  the falling clock edge. The memory image is loaded while reset is low.
*/
`timescale 1ns/1ps
`include "cpu_config.svh"

module tb_cpu_top;

  localparam logic [31:0] SEED        = 32'h73fa_6ffe;
  localparam logic [7:0]  ILLEGAL_OP  = 8'h02;
  localparam int          N_GROUPS    = 48;
  localparam int          HALT_CYCLES = 20;
  localparam int          TRACE_LIMIT = 100000;

  logic                 clk = 1'b0;
  logic                 resetn;
  logic [`DATA_W-1:0]   rd_data;
  logic [`ADDR_W-1:0]   address;
  logic [`DATA_W-1:0]   wr_data;
  logic                 wr_enable;

  logic [7:0] mem   [0:65535];
  logic [7:0] image [0:65535];

  // Expected bus activity with one entry per clock cycle
  logic [15:0] exp_addr_q[$];
  logic        exp_we_q[$];
  logic [7:0]  exp_wd_q[$];

  // Reference model state and program builder cursor
  logic [7:0]  ra;
  logic [7:0]  rx;
  logic [7:0]  ry;
  logic        rc;
  logic [15:0] bpc;
  logic [15:0] vector;
  logic [15:0] store_ptr;

  int errors;
  int checks;

  logic [7:0] alu_ops [0:5] = '{`OP_ADC_ABS, `OP_SBC_ABS, `OP_AND_ABS,
                                `OP_ORA_ABS, `OP_EOR_ABS, `OP_CMP_ABS};
  logic [7:0] shift_ops [0:3] = '{`OP_ASL_ACC, `OP_LSR_ACC, `OP_ROL_ACC, `OP_ROR_ACC};
  logic [7:0] flag_ops [0:3] = '{`OP_CLC, `OP_SEC, `OP_CLV, `OP_NOP};

  always #50 clk = ~clk;

  cpu_top i_cpu_top (
    .clk       (clk),
    .resetn    (resetn),
    .rd_data   (rd_data),
    .address   (address),
    .wr_data   (wr_data),
    .wr_enable (wr_enable)
  );

  // ----------------------------------------------------------------------
  // Memory model
  // ----------------------------------------------------------------------
  assign rd_data = mem[address];

  always @(posedge clk) begin
    if (!resetn) begin
      mem <= image;
    end else if (wr_enable) begin
      mem[address] <= wr_data;
    end
  end

  // ----------------------------------------------------------------------
  // Program builder
  // ----------------------------------------------------------------------
  task automatic put_byte(input logic [7:0] b);
    image[bpc] = b;
    bpc = bpc + 16'd1;
  endtask

  task automatic push_cycle(input logic [15:0] a, input logic we, input logic [7:0] wd);
    exp_addr_q.push_back(a);
    exp_we_q.push_back(we);
    exp_wd_q.push_back(wd);
  endtask

  task automatic emit_single(input logic [7:0] op);
    push_cycle(bpc, 1'b0, 8'h00);
    push_cycle(bpc + 16'd1, 1'b0, 8'h00);
    put_byte(op);
  endtask

  task automatic emit_imm(input logic [7:0] op, input logic [7:0] val);
    push_cycle(bpc, 1'b0, 8'h00);
    push_cycle(bpc + 16'd1, 1'b0, 8'h00);
    put_byte(op);
    put_byte(val);
  endtask

  // Fetch and two operand bytes before the data cycle at the operand address
  task automatic emit_abs(input logic [7:0] op, input logic [15:0] opnd,
                          input logic we, input logic [7:0] wd);
    push_cycle(bpc, 1'b0, 8'h00);
    push_cycle(bpc + 16'd1, 1'b0, 8'h00);
    push_cycle(bpc + 16'd2, 1'b0, 8'h00);
    push_cycle(opnd, we, wd);
    put_byte(op);
    put_byte(opnd[7:0]);
    put_byte(opnd[15:8]);
  endtask

  // Skipped bytes hold an illegal opcode so a stray fetch halts the core
  task automatic emit_jmp(input logic [15:0] target);
    push_cycle(bpc, 1'b0, 8'h00);
    push_cycle(bpc + 16'd1, 1'b0, 8'h00);
    push_cycle(bpc + 16'd2, 1'b0, 8'h00);
    put_byte(`OP_JMP_ABS);
    put_byte(target[7:0]);
    put_byte(target[15:8]);
    while (bpc != target) begin
      put_byte(ILLEGAL_OP);
    end
  endtask

  task automatic set_reg(input int sel, input logic [7:0] val);
    if (sel == 1) begin
      rx = val;
    end else if (sel == 2) begin
      ry = val;
    end else begin
      ra = val;
    end
  endtask

  task automatic emit_store(input int sel);
    logic [7:0] op;
    logic [7:0] val;
    op  = (sel == 1) ? `OP_STX_ABS : (sel == 2) ? `OP_STY_ABS : `OP_STA_ABS;
    val = (sel == 1) ? rx : (sel == 2) ? ry : ra;
    emit_abs(op, store_ptr, 1'b1, val);
    store_ptr = store_ptr + 16'd1;
  endtask

  // ----------------------------------------------------------------------
  // Reference model with C meaning no borrow
  // ----------------------------------------------------------------------
  task automatic model_alu(input logic [7:0] op, input logic [7:0] m);
    logic [8:0] wide;
    wide = 9'd0;
    case (op)
      `OP_ADC_ABS: begin
        wide = {1'b0, ra} + {1'b0, m} + {8'd0, rc};
        ra = wide[7:0];
        rc = wide[8];
      end
      `OP_SBC_ABS: begin
        wide = {1'b0, ra} - {1'b0, m} - {8'd0, ~rc};
        ra = wide[7:0];
        rc = ~wide[8];
      end
      `OP_AND_ABS: ra = ra & m;
      `OP_ORA_ABS: ra = ra | m;
      `OP_EOR_ABS: ra = ra ^ m;
      `OP_CMP_ABS: rc = (ra >= m);
      default: ;
    endcase
  endtask

  task automatic model_shift(input logic [7:0] op);
    logic old_c;
    old_c = rc;
    case (op)
      `OP_ASL_ACC: begin
        rc = ra[7];
        ra = {ra[6:0], 1'b0};
      end
      `OP_LSR_ACC: begin
        rc = ra[0];
        ra = {1'b0, ra[7:1]};
      end
      `OP_ROL_ACC: begin
        rc = ra[7];
        ra = {ra[6:0], old_c};
      end
      default: begin
        rc = ra[0];
        ra = {old_c, ra[7:1]};
      end
    endcase
  endtask

  task automatic build_program();
    int          kind;
    int          sel;
    logic [7:0]  op;
    logic [7:0]  val;
    logic [15:0] da;
    for (int i = 0; i < 65536; i++) begin
      image[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5a;
    end
    for (int i = 0; i < 256; i++) begin
      image[16'h8000 + i] = 8'($urandom);
    end
    vector = 16'h0200 + 16'($urandom % 256);
    image[`RESET_VEC_LO] = vector[7:0];
    image[`RESET_VEC_HI] = vector[15:8];
    bpc       = vector;
    store_ptr = 16'h9000;
    rx = 8'h00;
    ry = 8'h00;
    rc = 1'b0;

    // A is unknown after reset while X and Y start at zero
    val = 8'($urandom);
    emit_imm(`OP_LDA_IMM, val);
    ra = val;
    emit_store(0);
    emit_store(1);
    emit_store(2);

    // Group kinds and opcodes rotate so that every kept opcode appears
    for (int g = 0; g < N_GROUPS; g++) begin
      kind = g % 5;
      sel  = (g / 5) % 3;
      da   = 16'h8000 | 16'($urandom % 256);
      case (kind)
        0: begin
          val = 8'($urandom);
          op  = (sel == 1) ? `OP_LDX_IMM : (sel == 2) ? `OP_LDY_IMM : `OP_LDA_IMM;
          emit_imm(op, val);
          set_reg(sel, val);
          emit_store(sel);
        end
        1: begin
          op = (sel == 1) ? `OP_LDX_ABS : (sel == 2) ? `OP_LDY_ABS : `OP_LDA_ABS;
          emit_abs(op, da, 1'b0, 8'h00);
          set_reg(sel, image[da]);
          emit_store(sel);
        end
        2: begin
          op = flag_ops[(g / 5) % 4];
          emit_single(op);
          if (op == `OP_CLC) rc = 1'b0;
          if (op == `OP_SEC) rc = 1'b1;
          op = alu_ops[(g / 5) % 6];
          emit_abs(op, da, 1'b0, 8'h00);
          model_alu(op, image[da]);
          // CMP only moves C and the ADC makes it visible
          if (op == `OP_CMP_ABS) begin
            da = 16'h8000 | 16'($urandom % 256);
            emit_abs(`OP_ADC_ABS, da, 1'b0, 8'h00);
            model_alu(`OP_ADC_ABS, image[da]);
          end
          emit_store(0);
        end
        3: begin
          op = shift_ops[(g / 5) % 4];
          emit_single(op);
          model_shift(op);
          emit_store(0);
        end
        default: emit_jmp(bpc + 16'd3 + 16'($urandom % 8));
      endcase
    end

    // Halt and the bus must then stay frozen
    emit_single(ILLEGAL_OP);
    for (int i = 0; i < HALT_CYCLES; i++) begin
      push_cycle(bpc, 1'b0, 8'h00);
    end
  endtask

  // ----------------------------------------------------------------------
  // Bus checks
  // ----------------------------------------------------------------------
  task automatic check_cycle();
    logic [15:0] ea;
    logic        ew;
    logic [7:0]  ed;
    ea = exp_addr_q.pop_front();
    ew = exp_we_q.pop_front();
    ed = exp_wd_q.pop_front();
    checks++;
    assert (address === ea) else begin
      errors++;
      $display("error address: got %h expected %h", address, ea);
    end
    assert (wr_enable === ew) else begin
      errors++;
      $display("error wr_enable: got %h expected %h at address %h", wr_enable, ew, ea);
    end
    if (ew) begin
      assert (wr_data === ed) else begin
        errors++;
        $display("error wr_data: got %h expected %h at address %h", wr_data, ed, ea);
      end
    end
  endtask

  task automatic wait_for_vector(output logic found);
    int n;
    found = 1'b0;
    n = 0;
    @(negedge clk);
    while ((address === `RESET_VEC_LO || address === `RESET_VEC_HI) && n < 16) begin
      @(negedge clk);
      n++;
    end
    if (address === `RESET_VEC_LO || address === `RESET_VEC_HI) begin
      errors++;
      $display("timeout: the core never left the reset vector reads");
    end else begin
      found = 1'b1;
      checks++;
      assert (address === vector) else begin
        errors++;
        $display("error address: got %h expected %h for the first fetch", address, vector);
      end
    end
  endtask

  task automatic walk_trace();
    int n;
    n = 0;
    while (exp_addr_q.size() > 0 && n < TRACE_LIMIT) begin
      check_cycle();
      n++;
      if (exp_addr_q.size() > 0) begin
        @(negedge clk);
      end
    end
    if (exp_addr_q.size() > 0) begin
      errors++;
      $display("timeout: the expected bus trace was not completed");
    end
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin
    logic found;
    resetn = 1'b0;
    errors = 0;
    checks = 0;
    void'($urandom(SEED));
    build_program();
    repeat (2) @(posedge clk);
    #1;
    resetn = 1'b1;
    wait_for_vector(found);
    if (found) begin
      walk_trace();
    end
    $display("run complete: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+include
src/cpu_pkg.sv
src/alu_if.sv
src/cpu_alu.sv
src/cpu_decoder.sv
src/cpu_sequencer.sv
src/cpu_datapath.sv
src/cpu_top.sv
bench/tb_cpu_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the 6502 subset core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module tb_cpu_top -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -Fqx '>>> PASS'; then
  exit 0
fi
exit 1
